//--- Bender.yml
package:
  name: txb_bridge

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/txb_pkg.sv
      - verilog/txb_trans_if.sv
      - verilog/txb_fifo.sv
      - verilog/txb_addr_trans.sv
      - verilog/txb_avl_cntrl.sv
      - verilog/txb_tlp_framer.sv
      - verilog/txb_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - verif/tb_txb.sv

//--- files.f
+incdir+verilog
verilog/txb_pkg.sv
verilog/txb_trans_if.sv
verilog/txb_fifo.sv
verilog/txb_addr_trans.sv
verilog/txb_avl_cntrl.sv
verilog/txb_tlp_framer.sv
verilog/txb_top.sv
verif/tb_txb.sv

//--- verif/tb_txb.sv
// Testbench for the Avalon to PCIe transmit bridge
// Queue model of the stream beats checked by assertions under back-pressure
`timescale 1ns/1ps
`include "txb_params.svh"

module tb_txb;

  localparam int          ACCEPT_LIMIT = 200;   // Cycles per Avalon beat
  localparam int          DRAIN_LIMIT  = 3000;
  localparam logic [12:0] BUS_DEV      = 13'h0A5;
  localparam logic [7:0]  FMT_MRD32    = 8'h00;
  localparam logic [7:0]  FMT_MRD64    = 8'h20;
  localparam logic [7:0]  FMT_MWR32    = 8'h40;
  localparam logic [7:0]  FMT_MWR64    = 8'h60;
  localparam int          READY_ON     = 0;
  localparam int          READY_RANDOM = 1;
  localparam int          READY_STALL  = 2;

  typedef struct packed {
    logic        sop;
    logic        eop;
    logic [63:0] data;
  } beat_t;

  logic                        AvlClk_i = 1'b0;
  logic                        Rstn_i;
  logic                        TxChipSelect_i;
  logic                        TxRead_i;
  logic                        TxWrite_i;
  logic [`TXB_DATA_W-1:0]      TxWriteData_i;
  logic [`TXB_BURST_W-1:0]     TxBurstCount_i;
  logic [`TXB_AVL_ADDR_W-1:0]  TxAddress_i;
  logic [`TXB_DATA_W/8-1:0]    TxByteEnable_i;
  logic                        TxWaitRequest_o;
  logic [2:0]                  AdTrAddress_i;
  logic [3:0]                  AdTrByteEnable_i;
  logic                        AdTrWriteVld_i;
  logic [31:0]                 AdTrWriteData_i;
  logic                        AdTrReadVld_i;
  logic [31:0]                 AdTrReadData_o;
  logic                        AdTrReadVld_o;
  logic [12:0]                 BusDev_i;
  logic                        TxStReady_i;
  logic [`TXB_DATA_W-1:0]      TxStData_o;
  logic                        TxStSop_o;
  logic                        TxStEop_o;
  logic                        TxStValid_o;

  beat_t       exp_q[$];        // Beats still to appear on the stream
  beat_t       exp_beat;        // Head of the queue, refreshed at negedge
  logic        exp_avail = 1'b0;
  logic        beat_due  = 1'b0;
  logic [63:0] map_model [`TXB_MAP_ENTRIES];
  logic [7:0]  read_tag;
  int          ready_mode;

  txb_top dut0 (.*);

  always #10 AvlClk_i = ~AvlClk_i;

  // Ready follows the mode sampled at the clock edge
  always @(posedge AvlClk_i)
  begin : ready_drive
    int mode;
    mode = ready_mode;
    #2;
    case (mode)
      READY_RANDOM: TxStReady_i = ($urandom % 3) != 0;
      READY_STALL:  TxStReady_i = 1'b0;
      default:      TxStReady_i = 1'b1;
    endcase
  end

  // A handshake seen at negedge completes at the next posedge
  always @(negedge AvlClk_i)
  begin
    if (beat_due && exp_q.size() > 0)
      void'(exp_q.pop_front());
    beat_due  = Rstn_i && TxStValid_o && TxStReady_i;
    exp_avail = (exp_q.size() > 0);
    if (exp_avail)
      exp_beat = exp_q[0];
  end

  task automatic report_error(input string msg);
    $display("[FAIL] %0t ns %s", $time, msg);
    $display("CHECKS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    $display("CHECKS FAILED");
    $fatal(1, "run stopped on a timeout");
  endtask

  a_reset_low: assert property (@(negedge AvlClk_i) !Rstn_i |->
      (!TxStValid_o && !TxStSop_o && !TxStEop_o && TxWaitRequest_o))
    else report_error("stream outputs or waitrequest wrong during reset");

  a_beat_expected: assert property (@(posedge AvlClk_i) disable iff (!Rstn_i)
      (TxStValid_o && TxStReady_i) |-> exp_avail)
    else report_error("stream beat taken while the model expects none");

  a_beat_match: assert property (@(posedge AvlClk_i) disable iff (!Rstn_i)
      (TxStValid_o && TxStReady_i && exp_avail) |->
      (TxStData_o == exp_beat.data && TxStSop_o == exp_beat.sop &&
       TxStEop_o == exp_beat.eop))
    else report_error("stream beat differs from the model");

  a_stall_hold: assert property (@(posedge AvlClk_i) disable iff (!Rstn_i)
      (TxStValid_o && !TxStReady_i) |=>
      (TxStValid_o && $stable(TxStData_o) && $stable(TxStSop_o) && $stable(TxStEop_o)))
    else report_error("stream outputs changed while stalled");

  a_read_latency: assert property (@(posedge AvlClk_i) disable iff (!Rstn_i)
      AdTrReadVld_o == $past(AdTrReadVld_i))
    else report_error("register read valid not one cycle after the request");

  function automatic logic [63:0] header_beat(input logic [7:0] fmt, input logic [9:0] len,
                                              input logic [3:0] fbe, input logic [3:0] lbe,
                                              input logic [7:0] tag);
    return {BUS_DEV, 3'b000, tag, lbe, fbe, fmt, 14'h0, len};  // DW1 high, DW0 low
  endfunction

  function automatic logic [63:0] addr_beat(input logic [63:0] addr, input logic wide);
    return wide ? {addr[31:0], addr[63:32]} : {addr[31:0], 32'h0};
  endfunction

  function automatic logic [63:0] translate(input logic [`TXB_AVL_ADDR_W-1:0] addr);
    logic [63:0] entry;
    entry = map_model[addr[`TXB_AVL_ADDR_W-1:`TXB_PASS_THRU_BITS]];
    return {entry[63:`TXB_PASS_THRU_BITS], addr[`TXB_PASS_THRU_BITS-1:0]};
  endfunction

  function automatic logic wide_entry(input logic [`TXB_AVL_ADDR_W-1:0] addr);
    return |map_model[addr[`TXB_AVL_ADDR_W-1:`TXB_PASS_THRU_BITS]][63:32];
  endfunction

  task automatic push_beat(input logic [63:0] data, input logic sop, input logic eop);
    beat_t b;
    b.data = data;
    b.sop  = sop;
    b.eop  = eop;
    exp_q.push_back(b);
  endtask

  task automatic table_write(input logic [2:0] sel, input logic [3:0] be,
                             input logic [31:0] data);
    logic [31:0] mask;
    logic [31:0] word;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    word = sel[0] ? map_model[sel[2:1]][63:32] : map_model[sel[2:1]][31:0];
    word = (word & ~mask) | (data & mask);  // Untouched lanes keep old bytes
    if (sel[0])
      map_model[sel[2:1]][63:32] = word;
    else
      map_model[sel[2:1]][31:0] = word;
    AdTrAddress_i    = sel;
    AdTrByteEnable_i = be;
    AdTrWriteData_i  = data;
    AdTrWriteVld_i   = 1'b1;
    @(posedge AvlClk_i);
    #2;
    AdTrWriteVld_i   = 1'b0;
  endtask

  task automatic table_read(input logic [2:0] sel);
    logic [31:0] expected;
    expected = sel[0] ? map_model[sel[2:1]][63:32] : map_model[sel[2:1]][31:0];
    AdTrAddress_i = sel;
    AdTrReadVld_i = 1'b1;
    @(posedge AvlClk_i);
    #2;
    AdTrReadVld_i = 1'b0;
    @(negedge AvlClk_i);
    assert (AdTrReadVld_o && AdTrReadData_o == expected)
      else report_error($sformatf("table word %0d read %h, expected %h",
                                  sel, AdTrReadData_o, expected));
    @(posedge AvlClk_i);
    #2;
  endtask

  // Returns 2 ns after the edge that took the beat
  task automatic wait_accept(input string what);
    int   waited;
    logic busy;
    waited = 0;
    busy   = 1'b1;
    while (busy)
    begin
      @(negedge AvlClk_i);
      busy = TxWaitRequest_o;
      @(posedge AvlClk_i);
      #2;
      waited++;
      if (busy && waited > ACCEPT_LIMIT)
        report_timeout({"the Avalon side to accept a ", what});
    end
  endtask

  task automatic release_bus;
    TxChipSelect_i = 1'b0;
    TxRead_i       = 1'b0;
    TxWrite_i      = 1'b0;
  endtask

  task automatic avl_write(input logic [`TXB_AVL_ADDR_W-1:0] addr, input int burst);
    logic [63:0] dat [8];
    logic [7:0]  be [8];
    logic [63:0] pcie;
    logic        wide;
    for (int i = 0; i < burst; i++)
    begin
      dat[i] = {$urandom, $urandom};
      be[i]  = 8'($urandom);
    end
    pcie = translate(addr);
    wide = wide_entry(addr);
    push_beat(header_beat(wide ? FMT_MWR64 : FMT_MWR32, 10'(2 * burst), be[0][3:0],
                          be[burst-1][7:4], 8'h00), 1'b1, 1'b0);
    push_beat(addr_beat(pcie, wide), 1'b0, 1'b0);
    for (int i = 0; i < burst; i++)
      push_beat(dat[i], 1'b0, i == burst - 1);
    for (int i = 0; i < burst; i++)
    begin
      TxChipSelect_i = 1'b1;
      TxWrite_i      = 1'b1;
      TxRead_i       = 1'b0;
      TxBurstCount_i = 4'(burst);
      TxAddress_i    = addr;
      TxByteEnable_i = be[i];
      TxWriteData_i  = dat[i];
      wait_accept("write beat");
    end
    release_bus();
  endtask

  // Drives and predicts a read but leaves acceptance to the caller
  task automatic queue_read(input logic [`TXB_AVL_ADDR_W-1:0] addr, input logic [7:0] be);
    logic wide;
    wide = wide_entry(addr);
    push_beat(header_beat(wide ? FMT_MRD64 : FMT_MRD32, 10'd2, be[3:0], be[7:4], read_tag),
              1'b1, 1'b0);
    push_beat(addr_beat(translate(addr), wide), 1'b0, 1'b1);  // No payload for reads
    read_tag++;
    TxChipSelect_i = 1'b1;
    TxRead_i       = 1'b1;
    TxWrite_i      = 1'b0;
    TxBurstCount_i = 4'd1;
    TxAddress_i    = addr;
    TxByteEnable_i = be;
  endtask

  task automatic avl_read(input logic [`TXB_AVL_ADDR_W-1:0] addr, input logic [7:0] be);
    queue_read(addr, be);
    wait_accept("read");
    release_bus();
  endtask

  task automatic wait_drain(input string what);
    int waited;
    waited = 0;
    while (exp_q.size() != 0)
    begin
      @(posedge AvlClk_i);
      #2;
      waited++;
      if (waited > DRAIN_LIMIT)
        report_timeout({"the stream to deliver all beats of the ", what});
    end
  endtask

  initial
  begin
    logic [`TXB_AVL_ADDR_W-1:0] addr;
    void'($urandom(32'h7e70));
    Rstn_i           = 1'b0;
    TxChipSelect_i   = 1'b0;
    TxRead_i         = 1'b0;
    TxWrite_i        = 1'b0;
    TxWriteData_i    = '0;
    TxBurstCount_i   = 4'd1;
    TxAddress_i      = '0;
    TxByteEnable_i   = '0;
    AdTrAddress_i    = '0;
    AdTrByteEnable_i = '0;
    AdTrWriteVld_i   = 1'b0;
    AdTrWriteData_i  = '0;
    AdTrReadVld_i    = 1'b0;
    BusDev_i         = BUS_DEV;
    TxStReady_i      = 1'b1;
    ready_mode       = READY_ON;
    read_tag         = 8'h00;
    for (int e = 0; e < `TXB_MAP_ENTRIES; e++)
      map_model[e] = '0;

    repeat (4) @(posedge AvlClk_i);
    #2;
    Rstn_i = 1'b1;
    @(negedge AvlClk_i);
    assert (!TxStValid_o && !TxStSop_o && !TxStEop_o)
      else report_error("stream outputs not low after reset");
    @(posedge AvlClk_i);
    #2;

    // Entries 0 and 2 give 32-bit addresses, 1 and 3 give 64-bit ones
    table_write(3'b000, 4'hF, 32'h9AC0_1234);  // Low bits are ignored
    table_write(3'b010, 4'hF, 32'h5F40_0000);
    table_write(3'b011, 4'hF, 32'h0000_00A7);
    table_write(3'b100, 4'hF, 32'h1122_3344);
    table_write(3'b100, 4'b0101, 32'hAABB_CCDD);  // Partial merge
    table_write(3'b110, 4'hF, 32'hC000_0000);
    table_write(3'b111, 4'b0011, 32'h0000_BEEF);
    for (int s = 0; s < 8; s++)
      table_read(3'(s));

    avl_write(24'h01_2340, 4);
    avl_write(24'h01_0008, 1);
    avl_write(24'h4A_B000, 8);
    avl_write(24'h40_0040, 3);
    wait_drain("write bursts");

    avl_read(24'h81_0100, 8'($urandom));
    avl_read(24'hC3_2200, 8'($urandom));
    avl_read(24'h00_0800, 8'($urandom));
    wait_drain("reads");

    ready_mode = READY_RANDOM;
    for (int n = 0; n < 10; n++)
    begin
      addr = {2'($urandom), 19'($urandom), 3'b000};
      if ($urandom % 2)
        avl_write(addr, 1 + ($urandom % 8));
      else
        avl_read(addr, 8'($urandom));
    end
    wait_drain("random traffic");

    // Framer holds one command, the FIFO the next eight
    ready_mode = READY_STALL;
    for (int n = 0; n < `TXB_CMD_DEPTH + 1; n++)
      avl_read(n[0] ? 24'hC0_0010 : 24'h80_0020, 8'hFF);
    queue_read(24'h40_0400, 8'h0F);
    repeat (12)
    begin
      @(negedge AvlClk_i);
      assert (TxWaitRequest_o)
        else report_error("waitrequest low while the command FIFO is full");
      @(posedge AvlClk_i);
      #2;
    end
    ready_mode = READY_RANDOM;
    wait_accept("read behind a full command FIFO");
    release_bus();
    wait_drain("command FIFO fill");

    ready_mode = READY_ON;
    repeat (10) @(posedge AvlClk_i);  // Any stray beat trips the model
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

//--- verilog/txb_addr_trans.sv
// Avalon to PCIe address translation table
// Register port for programming and readback, one-cycle lookup
`timescale 1ns/1ps
`include "txb_params.svh"

module txb_addr_trans (
  input  logic                      AvlClk_i,
  input  logic                      Rstn_i,
  txb_trans_if.xlat                 Trans,
  input  logic [`TXB_MAP_IDX_W:0]   AdTrAddress_i,
  input  logic [3:0]                AdTrByteEnable_i,
  input  logic                      AdTrWriteVld_i,
  input  logic [31:0]               AdTrWriteData_i,
  input  logic                      AdTrReadVld_i,
  output logic [31:0]               AdTrReadData_o,
  output logic                      AdTrReadVld_o
);

  logic [63:0]               map_q [`TXB_MAP_ENTRIES];
  logic [`TXB_MAP_IDX_W-1:0] reg_idx;
  logic                      reg_hi;
  logic [`TXB_MAP_IDX_W-1:0] xlat_idx;

  assign reg_idx  = AdTrAddress_i[`TXB_MAP_IDX_W:1];
  assign reg_hi   = AdTrAddress_i[0];  // High word select
  assign xlat_idx = Trans.avl_addr[`TXB_AVL_ADDR_W-1:`TXB_PASS_THRU_BITS];

  // Byte-lane writes into the selected half
  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      for (int e = 0; e < `TXB_MAP_ENTRIES; e++)
        map_q[e] <= '0;
    end
    else if (AdTrWriteVld_i)
    begin
      for (int b = 0; b < 4; b++)
        if (AdTrByteEnable_i[b])
          map_q[reg_idx][reg_hi*32 + b*8 +: 8] <= AdTrWriteData_i[b*8 +: 8];
    end
  end

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      AdTrReadVld_o <= 1'b0;
      Trans.done    <= 1'b0;
    end
    else
    begin
      AdTrReadVld_o <= AdTrReadVld_i;
      Trans.done    <= Trans.req;
    end
  end

  always_ff @(posedge AvlClk_i)
  begin
    if (AdTrReadVld_i)
      AdTrReadData_o <= reg_hi ? map_q[reg_idx][63:32] : map_q[reg_idx][31:0];
    if (Trans.req)
    begin
      // Entry supplies the upper bits, Avalon the offset
      Trans.pcie_addr <= {map_q[xlat_idx][63:`TXB_PASS_THRU_BITS],
                          Trans.avl_addr[`TXB_PASS_THRU_BITS-1:0]};
      Trans.space64   <= |map_q[xlat_idx][63:32];
    end
  end

endmodule

//--- verilog/txb_avl_cntrl.sv
// Avalon slave control for the transmit bridge
// Accepts bursts, pushes write data, translates the address and queues a command
`timescale 1ns/1ps
`include "txb_params.svh"

module txb_avl_cntrl (
  input  logic                                   AvlClk_i,
  input  logic                                   Rstn_i,
  input  logic                                   TxChipSelect_i,
  input  logic                                   TxRead_i,
  input  logic                                   TxWrite_i,
  input  logic [`TXB_BURST_W-1:0]                TxBurstCount_i,
  input  logic [`TXB_AVL_ADDR_W-1:0]             TxAddress_i,
  input  logic [`TXB_DATA_W/8-1:0]               TxByteEnable_i,
  output logic                                   TxWaitRequest_o,
  txb_trans_if.ctrl                              Trans,
  input  logic                                   CmdFull_i,
  output logic                                   CmdPush_o,
  output txb_pkg::txb_cmd_t                      Cmd_o,
  input  logic [$clog2(`TXB_WRDAT_DEPTH+1)-1:0]  WrDatCount_i,
  output logic                                   WrDatPush_o
);
  import txb_pkg::*;

  typedef enum logic [1:0] {ST_INIT, ST_IDLE, ST_BURST, ST_WAIT} state_e;

  state_e                     state_q;
  txb_cmd_t                   cmd_q;
  logic [`TXB_BURST_W-1:0]    beats_left_q;
  logic [7:0]                 tag_q;
  logic                       xlat_ok_q;
  logic                       req_q;
  logic [`TXB_AVL_ADDR_W-1:0] addr_q;
  logic                       room;
  logic                       accept;
  logic                       first_beat;

  // A write needs space for its whole burst up front
  assign room = ~CmdFull_i &
                (~TxWrite_i | ((WrDatCount_i + TxBurstCount_i) <= `TXB_WRDAT_DEPTH));

  assign TxWaitRequest_o = (state_q == ST_INIT) | (state_q == ST_WAIT) |
                           ((state_q == ST_IDLE) & ~room);
  assign accept      = TxChipSelect_i & (TxRead_i | TxWrite_i) & ~TxWaitRequest_o;
  assign first_beat  = accept & (state_q == ST_IDLE);
  assign WrDatPush_o = accept & TxWrite_i;
  assign CmdPush_o   = (state_q == ST_WAIT) & xlat_ok_q;  // Burst done and address known
  assign Cmd_o       = cmd_q;

  assign Trans.req      = req_q;
  assign Trans.avl_addr = addr_q;

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      state_q      <= ST_INIT;
      beats_left_q <= '0;
      tag_q        <= '0;
      xlat_ok_q    <= 1'b0;
      req_q        <= 1'b0;
    end
    else
    begin
      req_q <= first_beat;
      if (Trans.done)
        xlat_ok_q <= 1'b1;
      else if (CmdPush_o)
        xlat_ok_q <= 1'b0;

      case (state_q)
        ST_INIT: state_q <= ST_IDLE;
        ST_IDLE:
          if (first_beat)
          begin
            beats_left_q <= TxBurstCount_i - 1'b1;
            if (TxWrite_i && TxBurstCount_i > 1)
              state_q <= ST_BURST;
            else
              state_q <= ST_WAIT;
            if (!TxWrite_i)
              tag_q <= tag_q + 1'b1;  // Reads only
          end
        ST_BURST:
          if (WrDatPush_o)
          begin
            beats_left_q <= beats_left_q - 1'b1;
            if (beats_left_q == 1)
              state_q <= ST_WAIT;
          end
        default:
          if (CmdPush_o)
            state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge AvlClk_i)
  begin
    if (first_beat)
    begin
      addr_q         <= TxAddress_i;
      cmd_q.is_write <= TxWrite_i;
      cmd_q.len_dw   <= TxWrite_i ? 10'({TxBurstCount_i, 1'b0}) : 10'd2;
      cmd_q.first_be <= TxByteEnable_i[3:0];
      cmd_q.last_be  <= TxByteEnable_i[7:4];
      cmd_q.tag      <= TxWrite_i ? 8'd0 : tag_q;
    end
    else if (WrDatPush_o)
      cmd_q.last_be  <= TxByteEnable_i[7:4];  // Ends up with the last beat's lanes

    if (Trans.done)
    begin
      cmd_q.pcie_addr <= Trans.pcie_addr;
      cmd_q.space64   <= Trans.space64;
    end
  end

endmodule

//--- verilog/txb_fifo.sv
// Synchronous show-ahead FIFO with occupancy count
`timescale 1ns/1ps

module txb_fifo #(
  parameter int WIDTH = 64,
  parameter int DEPTH = 8
) (
  input  logic                       AvlClk_i,
  input  logic                       Rstn_i,
  input  logic                       Push_i,
  input  logic [WIDTH-1:0]           Data_i,
  input  logic                       Pop_i,
  output logic [WIDTH-1:0]           Data_o,
  output logic                       Empty_o,
  output logic                       Full_o,
  output logic [$clog2(DEPTH+1)-1:0] Count_o
);

  localparam int PTR_W = $clog2(DEPTH);

  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic             do_push;
  logic             do_pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign do_push = Push_i & ~Full_o;  // Overflow dropped
  assign do_pop  = Pop_i & ~Empty_o;
  assign Empty_o = (Count_o == 0);
  assign Full_o  = (Count_o == DEPTH);
  assign Data_o  = mem_q[rd_ptr_q];   // Head visible before the pop

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      Count_o  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr_q <= next_ptr(wr_ptr_q);
      if (do_pop)
        rd_ptr_q <= next_ptr(rd_ptr_q);
      case ({do_push, do_pop})
        2'b10:   Count_o <= Count_o + 1'b1;
        2'b01:   Count_o <= Count_o - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge AvlClk_i)
  begin
    if (do_push)
      mem_q[wr_ptr_q] <= Data_i;
  end

endmodule

//--- verilog/txb_params.svh
// Transmit bridge geometry
// Widths, FIFO depths and translation table layout

`ifndef TXB_PARAMS_SVH
`define TXB_PARAMS_SVH

// Avalon side
`define TXB_AVL_ADDR_W      24
`define TXB_DATA_W          64
`define TXB_BURST_W         4   // Bursts of 1 to 8 beats

// Translation table
`define TXB_MAP_ENTRIES     4
`define TXB_MAP_IDX_W       2   // Index bits above the pass-through boundary
`define TXB_PASS_THRU_BITS  22

// Queue depths
`define TXB_CMD_DEPTH       8
`define TXB_WRDAT_DEPTH     32

`endif

//--- verilog/txb_pkg.sv
// Transmit bridge types
// Queued command, TLP format codes and the stream beat views

package txb_pkg;

  // One queued request from the Avalon side
  typedef struct packed {
    logic        is_write;
    logic        space64;   // Needs a four-word header
    logic [63:0] pcie_addr;
    logic [9:0]  len_dw;
    logic [3:0]  first_be;
    logic [3:0]  last_be;
    logic [7:0]  tag;
  } txb_cmd_t;

  typedef enum logic [7:0] {
    MRD32 = 8'h00,
    MRD64 = 8'h20,
    MWR32 = 8'h40,
    MWR64 = 8'h60
  } tlp_fmt_e;

  // DW1 in the upper word, DW0 in the lower word
  typedef struct packed {
    logic [15:0] req_id;
    logic [7:0]  tag;
    logic [3:0]  last_be;
    logic [3:0]  first_be;
    tlp_fmt_e    fmt_type;
    logic [13:0] rsvd;
    logic [9:0]  length;
  } tlp_hdr_t;

  typedef union packed {
    tlp_hdr_t    hdr;
    logic [63:0] data;
  } tlp_beat_u;

endpackage

//--- verilog/txb_tlp_framer.sv
// TLP framer for the transmit stream
// Sends header beats from a queued command, then the write payload
`timescale 1ns/1ps
`include "txb_params.svh"

module txb_tlp_framer (
  input  logic                   AvlClk_i,
  input  logic                   Rstn_i,
  input  logic [12:0]            BusDev_i,
  input  logic                   CmdEmpty_i,
  input  txb_pkg::txb_cmd_t      Cmd_i,
  output logic                   CmdPop_o,
  input  logic [`TXB_DATA_W-1:0] WrDat_i,
  output logic                   WrDatPop_o,
  input  logic                   TxStReady_i,
  output logic [`TXB_DATA_W-1:0] TxStData_o,
  output logic                   TxStSop_o,
  output logic                   TxStEop_o,
  output logic                   TxStValid_o
);
  import txb_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_HDR0, ST_HDR1, ST_PAYLOAD} state_e;

  state_e                  state_q;
  txb_cmd_t                cmd_q;
  logic [`TXB_BURST_W-1:0] beats_left_q;
  logic                    advance;
  tlp_beat_u               hdr_beat;
  logic [63:0]             addr_beat;

  // Output register is free when empty or being taken
  assign advance    = ~TxStValid_o | TxStReady_i;
  assign CmdPop_o   = (state_q == ST_IDLE) & ~CmdEmpty_i;
  assign WrDatPop_o = (state_q == ST_PAYLOAD) & advance;

  always_comb
  begin
    if (cmd_q.is_write)
      hdr_beat.hdr.fmt_type = cmd_q.space64 ? MWR64 : MWR32;
    else
      hdr_beat.hdr.fmt_type = cmd_q.space64 ? MRD64 : MRD32;
    hdr_beat.hdr.req_id   = {BusDev_i, 3'b000};
    hdr_beat.hdr.tag      = cmd_q.tag;
    hdr_beat.hdr.last_be  = cmd_q.last_be;
    hdr_beat.hdr.first_be = cmd_q.first_be;
    hdr_beat.hdr.rsvd     = '0;
    hdr_beat.hdr.length   = cmd_q.len_dw;

    // Four-word header puts the high address DW first
    if (cmd_q.space64)
      addr_beat = {cmd_q.pcie_addr[31:0], cmd_q.pcie_addr[63:32]};
    else
      addr_beat = {cmd_q.pcie_addr[31:0], 32'h0};
  end

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      state_q      <= ST_IDLE;
      beats_left_q <= '0;
      TxStValid_o  <= 1'b0;
      TxStSop_o    <= 1'b0;
      TxStEop_o    <= 1'b0;
    end
    else
    begin
      if (advance)
      begin
        TxStValid_o <= (state_q != ST_IDLE);
        TxStSop_o   <= (state_q == ST_HDR0);
        TxStEop_o   <= ((state_q == ST_HDR1) & ~cmd_q.is_write) |
                       ((state_q == ST_PAYLOAD) & (beats_left_q == 1));
      end

      case (state_q)
        ST_IDLE:
          if (CmdPop_o)
            state_q <= ST_HDR0;
        ST_HDR0:
          if (advance)
          begin
            state_q      <= ST_HDR1;
            beats_left_q <= cmd_q.len_dw[`TXB_BURST_W:1];  // Two DW per beat
          end
        ST_HDR1:
          if (advance)
            state_q <= cmd_q.is_write ? ST_PAYLOAD : ST_IDLE;
        default:
          if (advance)
          begin
            beats_left_q <= beats_left_q - 1'b1;
            if (beats_left_q == 1)
              state_q <= ST_IDLE;
          end
      endcase
    end
  end

  always_ff @(posedge AvlClk_i)
  begin
    if (CmdPop_o)
      cmd_q <= Cmd_i;
    if (advance)
    begin
      case (state_q)
        ST_HDR0:    TxStData_o <= hdr_beat.data;
        ST_HDR1:    TxStData_o <= addr_beat;
        ST_PAYLOAD: TxStData_o <= WrDat_i;
        default:    ;
      endcase
    end
  end

endmodule

//--- verilog/txb_top.sv
// Avalon to PCIe transmit bridge top level
// Control, translation table, command and write-data FIFOs, framer
`timescale 1ns/1ps
`include "txb_params.svh"

module txb_top (
  input  logic                        AvlClk_i,
  input  logic                        Rstn_i,
  // Avalon slave
  input  logic                        TxChipSelect_i,
  input  logic                        TxRead_i,
  input  logic                        TxWrite_i,
  input  logic [`TXB_DATA_W-1:0]      TxWriteData_i,
  input  logic [`TXB_BURST_W-1:0]     TxBurstCount_i,
  input  logic [`TXB_AVL_ADDR_W-1:0]  TxAddress_i,
  input  logic [`TXB_DATA_W/8-1:0]    TxByteEnable_i,
  output logic                        TxWaitRequest_o,
  // Translation table registers
  input  logic [`TXB_MAP_IDX_W:0]     AdTrAddress_i,
  input  logic [3:0]                  AdTrByteEnable_i,
  input  logic                        AdTrWriteVld_i,
  input  logic [31:0]                 AdTrWriteData_i,
  input  logic                        AdTrReadVld_i,
  output logic [31:0]                 AdTrReadData_o,
  output logic                        AdTrReadVld_o,
  input  logic [12:0]                 BusDev_i,
  // PCIe stream
  input  logic                        TxStReady_i,
  output logic [`TXB_DATA_W-1:0]      TxStData_o,
  output logic                        TxStSop_o,
  output logic                        TxStEop_o,
  output logic                        TxStValid_o
);
  import txb_pkg::*;

  localparam int CMD_W       = $bits(txb_cmd_t);
  localparam int WRDAT_CNT_W = $clog2(`TXB_WRDAT_DEPTH + 1);

  txb_cmd_t               cmd_in;
  txb_cmd_t               cmd_out;
  logic                   cmd_push;
  logic                   cmd_pop;
  logic                   cmd_empty;
  logic                   cmd_full;
  logic                   wrdat_push;
  logic                   wrdat_pop;
  logic [`TXB_DATA_W-1:0] wrdat_out;
  logic [WRDAT_CNT_W-1:0] wrdat_count;

  txb_trans_if trans ();

  txb_avl_cntrl u_avl_cntrl (
    .AvlClk_i        (AvlClk_i),
    .Rstn_i          (Rstn_i),
    .TxChipSelect_i  (TxChipSelect_i),
    .TxRead_i        (TxRead_i),
    .TxWrite_i       (TxWrite_i),
    .TxBurstCount_i  (TxBurstCount_i),
    .TxAddress_i     (TxAddress_i),
    .TxByteEnable_i  (TxByteEnable_i),
    .TxWaitRequest_o (TxWaitRequest_o),
    .Trans           (trans.ctrl),
    .CmdFull_i       (cmd_full),
    .CmdPush_o       (cmd_push),
    .Cmd_o           (cmd_in),
    .WrDatCount_i    (wrdat_count),
    .WrDatPush_o     (wrdat_push)
  );

  txb_addr_trans u_addr_trans (
    .AvlClk_i         (AvlClk_i),
    .Rstn_i           (Rstn_i),
    .Trans            (trans.xlat),
    .AdTrAddress_i    (AdTrAddress_i),
    .AdTrByteEnable_i (AdTrByteEnable_i),
    .AdTrWriteVld_i   (AdTrWriteVld_i),
    .AdTrWriteData_i  (AdTrWriteData_i),
    .AdTrReadVld_i    (AdTrReadVld_i),
    .AdTrReadData_o   (AdTrReadData_o),
    .AdTrReadVld_o    (AdTrReadVld_o)
  );

  // Queued commands
  txb_fifo #(.WIDTH(CMD_W), .DEPTH(`TXB_CMD_DEPTH)) u_cmd_fifo (
    .AvlClk_i (AvlClk_i),
    .Rstn_i   (Rstn_i),
    .Push_i   (cmd_push),
    .Data_i   (cmd_in),
    .Pop_i    (cmd_pop),
    .Data_o   (cmd_out),
    .Empty_o  (cmd_empty),
    .Full_o   (cmd_full),
    .Count_o  ()
  );

  // Write payload whose count gives the room check
  txb_fifo #(.WIDTH(`TXB_DATA_W), .DEPTH(`TXB_WRDAT_DEPTH)) u_wrdat_fifo (
    .AvlClk_i (AvlClk_i),
    .Rstn_i   (Rstn_i),
    .Push_i   (wrdat_push),
    .Data_i   (TxWriteData_i),
    .Pop_i    (wrdat_pop),
    .Data_o   (wrdat_out),
    .Empty_o  (),
    .Full_o   (),
    .Count_o  (wrdat_count)
  );

  txb_tlp_framer u_tlp_framer (
    .AvlClk_i    (AvlClk_i),
    .Rstn_i      (Rstn_i),
    .BusDev_i    (BusDev_i),
    .CmdEmpty_i  (cmd_empty),
    .Cmd_i       (cmd_out),
    .CmdPop_o    (cmd_pop),
    .WrDat_i     (wrdat_out),
    .WrDatPop_o  (wrdat_pop),
    .TxStReady_i (TxStReady_i),
    .TxStData_o  (TxStData_o),
    .TxStSop_o   (TxStSop_o),
    .TxStEop_o   (TxStEop_o),
    .TxStValid_o (TxStValid_o)
  );

endmodule

//--- verilog/txb_trans_if.sv
// Translation request and result between Avalon control and the table
`timescale 1ns/1ps
`include "txb_params.svh"

interface txb_trans_if;
  logic                       req;        // One-cycle pulse
  logic [`TXB_AVL_ADDR_W-1:0] avl_addr;
  logic                       done;       // One cycle after req
  logic [63:0]                pcie_addr;
  logic                       space64;

  modport ctrl (
    output req, avl_addr,
    input  done, pcie_addr, space64
  );

  modport xlat (
    input  req, avl_addr,
    output done, pcie_addr, space64
  );
endinterface
